//--- harvard_mem.f
hw/avalon_pkg.sv
hw/cpu_port_pkg.sv
hw/lane_steer.sv
hw/bus_controller.sv
hw/avalon_ram.sv
hw/harvard_mem_top.sv
verification/harvard_mem_assertions.sv
verification/harvard_mem_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = harvard_mem_tb
FILELIST = harvard_mem.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100
PASS_MSG = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/harvard_mem_tb.sv
`timescale 1ns/1ps

module harvard_mem_tb import avalon_pkg::*, cpu_port_pkg::*;
;

  localparam int STALL_LIMIT = 20;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_FETCH,
    OP_READ_FETCH,
    OP_BOTH_FETCH      // both data strobes high, only the fetch may run
  } op_t;

  logic      clk;
  logic      rst_n;
  av_addr_t  instr_address;
  logic      instr_read;
  data_req_t data_req;
  av_data_t  instr_readdata;
  av_data_t  data_readdata;
  logic      clk_enable;
  logic      pause;
  av_req_t   av_cmd;

  string     names [$];
  op_t       ops [$];
  av_addr_t  daddrs [$];
  av_addr_t  iaddrs [$];
  av_data_t  wdatas [$];

  av_data_t    model [256];          // word image of the ram
  av_data_t    exp_data  = '0;
  av_data_t    exp_instr = '0;
  logic [31:0] rand_state = 32'h67b9_f3b9;
  int          mismatch_count = 0;
  int          stall_errors = 0;
  int          assert_fails;
  int          cycle_count = 0;
  int          cycle_limit = 1000;   // replaced once the table is built

  harvard_mem_top #(
    .WAIT_CYCLES (3)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_address  (instr_address),
    .instr_read     (instr_read),
    .data_req       (data_req),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable),
    .pause          (pause),
    .av_cmd         (av_cmd)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rand_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rand_state = x;
    return x;
  endfunction

  task automatic add_row(input string name, input op_t op, input av_addr_t daddr,
                         input av_addr_t iaddr);
    names.push_back(name);
    ops.push_back(op);
    daddrs.push_back(daddr);
    iaddrs.push_back(iaddr);
    wdatas.push_back(next_random());
  endtask

  task automatic check_data(input string name, input av_data_t exp, input av_data_t act);
    if (exp !== act)
    begin
      mismatch_count++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_be(input string name, input av_be_t exp, input av_be_t act);
    if (exp !== act)
    begin
      mismatch_count++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_state_bits(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      mismatch_count++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // enabled lanes take the write data moved up by the offset
  task automatic model_write(input av_addr_t addr, input av_data_t wdata);
    byte_off_t off;
    av_be_t    be;
    av_data_t  lanes;
    off   = addr[1:0];
    be    = av_be_t'(4'b1111 << off);
    lanes = wdata << (8 * off);
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        model[addr[9:2]][8*b +: 8] = lanes[8*b +: 8];
    end
  endtask

  task automatic run_row(input int i);
    string     name;
    op_t       op;
    av_addr_t  daddr;
    av_addr_t  iaddr;
    byte_off_t off;
    av_be_t    seen_be;
    logic      seen_lo;
    logic      saw_write;
    logic      first_is_data;
    int        stall;
    name      = names[i];
    op        = ops[i];
    daddr     = daddrs[i];
    iaddr     = iaddrs[i];
    off       = daddr[1:0];
    seen_be   = '0;
    seen_lo   = 1'b0;
    saw_write = 1'b0;
    stall     = 0;
    data_req.address   = daddr;
    data_req.writedata = wdatas[i];
    data_req.read  = (op == OP_READ) || (op == OP_READ_FETCH) || (op == OP_BOTH_FETCH);
    data_req.write = (op == OP_WRITE) || (op == OP_BOTH_FETCH);
    instr_address  = iaddr;
    instr_read     = (op == OP_FETCH) || (op == OP_READ_FETCH) || (op == OP_BOTH_FETCH);
    #1;
    first_is_data = av_cmd.read && (av_cmd.address == {daddr[31:2], 2'b00});
    while (pause && stall <= STALL_LIMIT)
    begin
      if (av_cmd.write)
      begin
        saw_write = 1'b1;
        seen_be   = av_cmd.byteenable;
        seen_lo   = |av_cmd.address[1:0];
      end
      @(posedge clk);
      #1;
      stall++;
    end
    if (stall > STALL_LIMIT)
    begin
      stall_errors++;
      $display("row %s: pause stayed high for more than %0d cycles", name, STALL_LIMIT);
    end
    case (op)
      OP_WRITE:
      begin
        model_write(daddr, wdatas[i]);
        check_be({name, " byteenable"}, av_be_t'(4'b1111 << off), seen_be);
        check_state_bits({name, " address low bits"}, 1'b0, seen_lo);
      end
      OP_READ:
        exp_data = model[daddr[9:2]] >> (8 * off);
      OP_FETCH:
        exp_instr = model[iaddr[9:2]];
      OP_READ_FETCH:
      begin
        exp_data  = model[daddr[9:2]] >> (8 * off);
        exp_instr = model[iaddr[9:2]];
        check_state_bits({name, " data first"}, 1'b1, first_is_data);
      end
      default:
      begin
        exp_instr = model[iaddr[9:2]];  // the data word must stay untouched
        check_state_bits({name, " no bus write"}, 1'b0, saw_write);
      end
    endcase
    check_data({name, " data_readdata"}, exp_data, data_readdata);
    check_data({name, " instr_readdata"}, exp_instr, instr_readdata);
    check_state_bits({name, " clk_enable"}, 1'b1, clk_enable);
    data_req.read  = 1'b0;
    data_req.write = 1'b0;
    instr_read     = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    rst_n         = 1'b0;
    instr_address = '0;
    instr_read    = 1'b0;
    data_req      = '0;
    for (int w = 0; w < 256; w++)
      model[w] = '0;
    add_row("wr_word",    OP_WRITE,      32'h10, 32'h0);
    add_row("rd_word",    OP_READ,       32'h10, 32'h0);
    add_row("wr_base",    OP_WRITE,      32'h20, 32'h0);
    add_row("wr_off1",    OP_WRITE,      32'h21, 32'h0);
    add_row("rd_merge1",  OP_READ,       32'h20, 32'h0);
    add_row("wr_off2",    OP_WRITE,      32'h22, 32'h0);
    add_row("rd_merge2",  OP_READ,       32'h20, 32'h0);
    add_row("wr_off3",    OP_WRITE,      32'h23, 32'h0);
    add_row("rd_merge3",  OP_READ,       32'h20, 32'h0);
    add_row("rd_off1",    OP_READ,       32'h21, 32'h0);
    add_row("rd_off2",    OP_READ,       32'h22, 32'h0);
    add_row("rd_off3",    OP_READ,       32'h23, 32'h0);
    add_row("fetch_only", OP_FETCH,      32'h0,  32'h20);
    add_row("fetch_zero", OP_FETCH,      32'h0,  32'h80);
    add_row("rd_fetch",   OP_READ_FETCH, 32'h13, 32'h20);
    add_row("fetch_keep", OP_FETCH,      32'h0,  32'h10);
    add_row("both_fetch", OP_BOTH_FETCH, 32'h10, 32'h20);
    add_row("rd_after",   OP_READ,       32'h10, 32'h0);
    add_row("wr_instr",   OP_WRITE,      32'h40, 32'h0);
    add_row("fetch_new",  OP_FETCH,      32'h0,  32'h40);
    cycle_limit = names.size() * 20 + 50;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    check_state_bits("reset pause", 1'b0, pause);
    check_state_bits("reset clk_enable", 1'b1, clk_enable);
    check_state_bits("reset read", 1'b0, av_cmd.read);
    check_state_bits("reset write", 1'b0, av_cmd.write);
    check_data("reset data_readdata", '0, data_readdata);
    check_data("reset instr_readdata", '0, instr_readdata);
    @(posedge clk);
    #1;
    for (int i = 0; i < names.size(); i++)
      run_row(i);
    assert_fails = UUT.u_bus_controller.u_checks.assert_failures;
    $display("errors: %0d mismatches, %0d stalls, %0d assertion failures",
             mismatch_count, stall_errors, assert_fails);
    if (mismatch_count == 0 && stall_errors == 0 && assert_fails == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- verification/harvard_mem_assertions.sv
`timescale 1ns/1ps

module harvard_mem_assertions import avalon_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    pause,
  input logic    clk_enable,
  input logic    waitrequest,
  input av_req_t av_cmd
);

  int assert_failures = 0;

  // a transfer in flight keeps the cpu stalled
  property p_stall_in_flight;
    @(posedge clk) disable iff (!rst_n)
      (av_cmd.read || av_cmd.write) |-> pause && !clk_enable;
  endproperty

  property p_single_strobe;
    @(posedge clk) disable iff (!rst_n) !(av_cmd.read && av_cmd.write);
  endproperty

  // avalon master must hold the command until the slave lets go
  property p_hold_while_wait;
    @(posedge clk) disable iff (!rst_n)
      (av_cmd.read || av_cmd.write) && waitrequest |=> $stable(av_cmd);
  endproperty

  a_stall_in_flight: assert property (p_stall_in_flight)
  else
  begin
    assert_failures++;
    $error("cpu was not stalled while a bus command was active");
  end

  a_single_strobe: assert property (p_single_strobe)
  else
  begin
    assert_failures++;
    $error("read and write are high together on the bus");
  end

  a_hold_while_wait: assert property (p_hold_while_wait)
  else
  begin
    assert_failures++;
    $error("bus command changed while waitrequest was high");
  end

endmodule

bind bus_controller harvard_mem_assertions u_checks (
  .clk         (clk),
  .rst_n       (rst_n),
  .pause       (pause),
  .clk_enable  (clk_enable),
  .waitrequest (waitrequest),
  .av_cmd      (av_cmd)
);

//--- hw/harvard_mem_top.sv
`timescale 1ns/1ps

module harvard_mem_top import avalon_pkg::*, cpu_port_pkg::*;
#(
  parameter int unsigned WAIT_CYCLES = 2,
  parameter int unsigned MEM_WORDS   = 256
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  av_addr_t  instr_address,
  input  logic      instr_read,
  input  data_req_t data_req,
  output av_data_t  instr_readdata,
  output av_data_t  data_readdata,
  output logic      clk_enable,
  output logic      pause,
  output av_req_t   av_cmd        // exported for observation
);

  logic     waitrequest;
  av_data_t ram_readdata;

  bus_controller u_bus_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_address  (instr_address),
    .instr_read     (instr_read),
    .data_req       (data_req),
    .waitrequest    (waitrequest),
    .readdata       (ram_readdata),
    .av_cmd         (av_cmd),
    .instr_readdata (instr_readdata),
    .data_readdata  (data_readdata),
    .clk_enable     (clk_enable),
    .pause          (pause)
  );

  avalon_ram #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .MEM_WORDS   (MEM_WORDS)
  ) u_avalon_ram (
    .clk         (clk),
    .rst_n       (rst_n),
    .av_cmd      (av_cmd),
    .waitrequest (waitrequest),
    .readdata    (ram_readdata)
  );

endmodule

//--- hw/avalon_ram.sv
`timescale 1ns/1ps

module avalon_ram import avalon_pkg::*;
#(
  parameter int unsigned WAIT_CYCLES = 2,
  parameter int unsigned MEM_WORDS   = 256   // power of two
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  av_req_t  av_cmd,
  output logic     waitrequest,
  output av_data_t readdata
);

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int unsigned CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES);

  av_data_t         mem [MEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [CNT_W-1:0] wait_cnt;
  logic             active;
  logic             done;

  assign word_idx = av_cmd.address[IDX_W+1:2];  // word address modulo depth
  assign active   = av_cmd.read | av_cmd.write;
  assign done     = active && (wait_cnt == WAIT_LAST);

  // high whenever idle or still counting
  assign waitrequest = ~done;
  assign readdata    = mem[word_idx];

  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wait_cnt <= '0;
    else if (!active || done)
      wait_cnt <= '0;                    // ready for the next command
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (done && av_cmd.write)
    begin
      for (int lane = 0; lane < AV_LANES; lane++)
      begin
        if (av_cmd.byteenable[lane])
          mem[word_idx][8*lane +: 8] <= av_cmd.writedata[8*lane +: 8];
      end
    end
  end

endmodule

//--- hw/bus_controller.sv
`timescale 1ns/1ps

module bus_controller import avalon_pkg::*, cpu_port_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  av_addr_t  instr_address,
  input  logic      instr_read,
  input  data_req_t data_req,
  input  logic      waitrequest,
  input  av_data_t  readdata,
  output av_req_t   av_cmd,
  output av_data_t  instr_readdata,
  output av_data_t  data_readdata,
  output logic      clk_enable,
  output logic      pause
);

  bus_state_t state;
  bus_state_t state_next;

  logic     data_valid;     // exactly one data strobe
  logic     any_req;
  logic     bus_done;       // transfer completes this cycle
  av_be_t   data_be;
  av_data_t data_wdata;
  av_data_t data_rdata;
  av_req_t  data_cmd;
  av_req_t  instr_cmd;

  lane_steer u_lane_steer (
    .offset        (byte_off_t'(data_req.address[1:0])),
    .wdata         (data_req.writedata),
    .rdata_raw     (readdata),
    .byteenable    (data_be),
    .wdata_lane    (data_wdata),
    .rdata_aligned (data_rdata)
  );

  assign data_valid = data_req.read ^ data_req.write;
  assign any_req    = data_valid | instr_read;
  assign bus_done   = (av_cmd.read | av_cmd.write) & ~waitrequest;

  always_comb
  begin
    data_cmd            = AV_REQ_IDLE;
    data_cmd.address    = {data_req.address[31:2], 2'b00};  // word aligned
    data_cmd.read       = data_req.read;
    data_cmd.write      = data_req.write;
    data_cmd.writedata  = data_wdata;
    data_cmd.byteenable = data_be;

    instr_cmd            = AV_REQ_IDLE;
    instr_cmd.address    = instr_address;
    instr_cmd.read       = 1'b1;
    instr_cmd.byteenable = AV_BE_ALL;
  end

  // command and stall for the current state
  always_comb
  begin
    av_cmd = AV_REQ_IDLE;
    pause  = 1'b0;
    case (state)
      IDLE:
      begin
        pause = any_req;                      // stall starts in the request cycle
        if (data_valid)
          av_cmd = data_cmd;                  // data goes first
        else if (instr_read)
          av_cmd = instr_cmd;
      end
      FETCH_DATA:
      begin
        pause  = 1'b1;
        av_cmd = data_cmd;
      end
      INSTR_SET, FETCH_INSTR:
      begin
        pause  = 1'b1;
        av_cmd = instr_cmd;
      end
      default:
      begin
        pause  = 1'b0;                        // halted, let the cpu step once
        av_cmd = AV_REQ_IDLE;
      end
    endcase
  end

  assign clk_enable = ~pause;

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (data_valid)
          state_next = FETCH_DATA;
        else if (instr_read)
          state_next = FETCH_INSTR;
      end
      FETCH_DATA:
      begin
        if (bus_done)
          state_next = instr_read ? INSTR_SET : HALTED;
      end
      INSTR_SET:   state_next = FETCH_INSTR;
      FETCH_INSTR:
      begin
        if (bus_done)
          state_next = HALTED;
      end
      default:     state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state          <= IDLE;
      data_readdata  <= '0;
      instr_readdata <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == FETCH_DATA && bus_done && data_req.read)
        data_readdata <= data_rdata;          // shifted down by the offset
      if (state == FETCH_INSTR && bus_done)
        instr_readdata <= readdata;
    end
  end

endmodule

//--- hw/lane_steer.sv
`timescale 1ns/1ps

module lane_steer import avalon_pkg::*, cpu_port_pkg::*;
(
  input  byte_off_t offset,         // low bits of the data address
  input  av_data_t  wdata,          // cpu write data, lsb aligned
  input  av_data_t  rdata_raw,      // word straight from the bus
  output av_be_t    byteenable,
  output av_data_t  wdata_lane,     // write data moved up to its lanes
  output av_data_t  rdata_aligned   // read data moved down to bit 0
);

  always_comb
  begin
    case (offset)
      OFF_BYTE0:
      begin
        byteenable    = AV_BE_ALL;
        wdata_lane    = wdata;
        rdata_aligned = rdata_raw;
      end
      OFF_BYTE1:
      begin
        byteenable    = 4'b1110;
        wdata_lane    = wdata << 8;
        rdata_aligned = rdata_raw >> 8;      // zero fill from the top
      end
      OFF_BYTE2:
      begin
        byteenable    = 4'b1100;
        wdata_lane    = wdata << 16;
        rdata_aligned = rdata_raw >> 16;
      end
      OFF_BYTE3:
      begin
        byteenable    = 4'b1000;             // top lane only
        wdata_lane    = wdata << 24;
        rdata_aligned = rdata_raw >> 24;
      end
      default:
      begin
        byteenable    = AV_BE_ALL;
        wdata_lane    = wdata;
        rdata_aligned = rdata_raw;
      end
    endcase
  end

endmodule

//--- hw/cpu_port_pkg.sv
package cpu_port_pkg;

  import avalon_pkg::*;

  typedef logic [1:0] byte_off_t;  // low two address bits

  // data port of the cpu; read and write high together is not a request
  typedef struct packed {
    av_addr_t address;
    logic     read;
    logic     write;
    av_data_t writedata;
  } data_req_t;

  // sequencer states of the bus controller
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    FETCH_INSTR = 3'd1,  // instruction read on the bus
    FETCH_DATA  = 3'd2,  // data read or write on the bus
    INSTR_SET   = 3'd3,  // turnaround from data to instruction
    HALTED      = 3'd4   // one cycle with the cpu running
  } bus_state_t;

  localparam byte_off_t OFF_BYTE0 = 2'd0;
  localparam byte_off_t OFF_BYTE1 = 2'd1;
  localparam byte_off_t OFF_BYTE2 = 2'd2;
  localparam byte_off_t OFF_BYTE3 = 2'd3;

endpackage

//--- hw/avalon_pkg.sv
package avalon_pkg;

  typedef logic [31:0] av_addr_t;  // byte address on the bus
  typedef logic [31:0] av_data_t;  // one bus word, also used on the cpu side
  typedef logic [3:0]  av_be_t;    // one bit per byte lane

  localparam int unsigned AV_LANES = 4;

  localparam av_be_t AV_BE_ALL = 4'b1111;  // full word access

  // command driven by the master; held steady while waitrequest is high
  typedef struct packed {
    av_addr_t address;     // word aligned by the controller
    logic     read;
    logic     write;
    av_data_t writedata;   // already lane steered
    av_be_t   byteenable;
  } av_req_t;

  localparam av_req_t AV_REQ_IDLE = '{
    address:    '0,
    read:       1'b0,
    write:      1'b0,
    writedata:  '0,
    byteenable: '0
  };

endpackage
